/* Makefile */
# Verilator build for the clock and reset generator
# override any variable on the command line, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= tb_crg_top
RTL_TOP   ?= crg_top
FILELIST  ?= crg_top.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing
PASS_MSG  ?= TB PASSED

SOURCES := $(filter-out +%,$(shell cat $(FILELIST)))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all lint lint_rtl sim clean

all: sim

# lint the testbench and everything below it
lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

# lint the design on its own
lint_rtl:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) \
		-Mdir $(BUILD_DIR) -o V$(TOP) -f $(FILELIST)

# run the simulation, fail unless the pass line shows up
sim: $(SIM_BIN)
	@out="$$(./$(SIM_BIN))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(BUILD_DIR)

/* crg_top.f */
verilog/crg_pkg.sv
verilog/pll_ctrl_if.sv
verilog/rst_sync.sv
verilog/rst_stretch.sv
verilog/pll_cfg_decode.sv
verilog/crg_top.sv
testbench/tb_crg_top.sv

/* testbench/tb_crg_top.sv */
`timescale 1ns/1ps

module tb_crg_top;
    import crg_pkg::*;

    // rst_core_n_o rises on this edge after rst_gen releases
    localparam int REL_EDGES      = int'(RST_CNT_END) + 6;
    localparam int RST_CYCLES     = 16;
    localparam int RAND_COUNT     = 256;
    localparam int TIMEOUT_CYCLES = 2 * REL_EDGES + RST_CYCLES + 64 + RAND_COUNT + 1000;

    // one pll bundle flattened, bypass first
    localparam int PLL_W = 1 + REFDIV_W + FBDIV_W + 2 * POSTDIV_W;
    localparam int DEC_W = 2 * PLL_W;

    logic                 sys_clk;
    logic                 rst_gen;
    logic [PLL_CFG_W-1:0] pll_cfg_i;
    logic                 rst_core_n_o;

    logic                 pll1_bypass_o;
    logic [REFDIV_W-1:0]  pll1_refdiv_o;
    logic [FBDIV_W-1:0]   pll1_fbdiv_o;
    logic [POSTDIV_W-1:0] pll1_postdiv1_o;
    logic [POSTDIV_W-1:0] pll1_postdiv2_o;

    logic                 pll2_bypass_o;
    logic [REFDIV_W-1:0]  pll2_refdiv_o;
    logic [FBDIV_W-1:0]   pll2_fbdiv_o;
    logic [POSTDIV_W-1:0] pll2_postdiv1_o;
    logic [POSTDIV_W-1:0] pll2_postdiv2_o;

    // decode comparison state
    logic             chk_en;
    logic [DEC_W-1:0] dec_exp;
    logic [DEC_W-1:0] dec_act;
    int               dec_checks = 0;
    int               dec_errs   = 0;
    int               cycle_cnt  = 0;

    // per-test bookkeeping
    string       test_name;
    int          test_checks;
    int          test_errs;
    int          dec_checks_base;
    int          dec_errs_base;
    int          tests_run;
    int          tests_failed;
    int          total_errs;
    integer      seed;
    logic [31:0] rnd_word;

    crg_top uut (
        .sys_clk         (sys_clk),
        .rst_gen         (rst_gen),
        .pll_cfg_i       (pll_cfg_i),
        .rst_core_n_o    (rst_core_n_o),
        .pll1_bypass_o   (pll1_bypass_o),
        .pll1_refdiv_o   (pll1_refdiv_o),
        .pll1_fbdiv_o    (pll1_fbdiv_o),
        .pll1_postdiv1_o (pll1_postdiv1_o),
        .pll1_postdiv2_o (pll1_postdiv2_o),
        .pll2_bypass_o   (pll2_bypass_o),
        .pll2_refdiv_o   (pll2_refdiv_o),
        .pll2_fbdiv_o    (pll2_fbdiv_o),
        .pll2_postdiv1_o (pll2_postdiv1_o),
        .pll2_postdiv2_o (pll2_postdiv2_o)
    );

    always #50 sys_clk = ~sys_clk;

    // expected pll outputs, pll1 in the upper half
    function automatic logic [DEC_W-1:0] ref_pll(input logic [PLL_CFG_W-1:0] cfg);
        logic [3:0]       sel1;
        logic [1:0]       sel2;
        logic [11:0]      fb1;
        logic [PLL_W-1:0] p1;
        logic [PLL_W-1:0] p2;
        sel1 = cfg[3:0];
        sel2 = cfg[5:4];
        fb1  = PLL1_FBDIV_BASE + PLL1_FBDIV_STEP * {8'd0, sel1};
        if (sel1 >= 4'd1 && sel1 <= 4'd8) begin
            p1 = {1'b0, PLL1_REFDIV, fb1, PLL1_POSTDIV1, PLL1_POSTDIV2};
        end else begin
            p1 = {1'b1, BYP_REFDIV, BYP_FBDIV, BYP_POSTDIV, BYP_POSTDIV};
        end
        case (sel2)
            2'd1: p2 = {1'b0, PLL2_MID_REFDIV, PLL2_MID_FBDIV,
                        PLL2_MID_POSTDIV1, PLL2_MID_POSTDIV2};
            2'd2: p2 = {1'b0, PLL2_HI_REFDIV, PLL2_HI_FBDIV,
                        PLL2_HI_POSTDIV1, PLL2_HI_POSTDIV2};
            default: p2 = {1'b1, BYP_REFDIV, BYP_FBDIV, BYP_POSTDIV, BYP_POSTDIV};
        endcase
        return {p1, p2};
    endfunction

    // decode outputs settle within the cycle, checked on the rising edge
    always @(posedge sys_clk) begin
        if (chk_en) begin
            dec_exp = ref_pll(pll_cfg_i);
            dec_act = {pll1_bypass_o, pll1_refdiv_o, pll1_fbdiv_o,
                       pll1_postdiv1_o, pll1_postdiv2_o,
                       pll2_bypass_o, pll2_refdiv_o, pll2_fbdiv_o,
                       pll2_postdiv1_o, pll2_postdiv2_o};
            dec_checks++;
            if (dec_act !== dec_exp) begin
                $display("FAILED %s: cfg %02h expected %h actual %h",
                         test_name, pll_cfg_i, dec_exp, dec_act);
                dec_errs++;
            end
        end
    end

    always @(posedge sys_clk) begin
        cycle_cnt++;
        if (cycle_cnt >= TIMEOUT_CYCLES) begin
            $display("timeout: run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TB FAILED");
            $finish;
        end
    end

    task automatic start_test(input string name);
        test_name       = name;
        test_checks     = 0;
        test_errs       = 0;
        dec_checks_base = dec_checks;
        dec_errs_base   = dec_errs;
    endtask

    task automatic finish_test();
        int errs;
        int checks;
        errs   = test_errs + (dec_errs - dec_errs_base);
        checks = test_checks + (dec_checks - dec_checks_base);
        tests_run++;
        total_errs += errs;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("test %-18s %0d checks, %0d errors", test_name, checks, errs);
    endtask

    // called on a falling edge
    task automatic apply_cfg(input logic [PLL_CFG_W-1:0] cfg);
        pll_cfg_i = cfg;
        chk_en    = 1'b1;
    endtask

    // lets the last applied value reach a rising edge
    task automatic drain_checks();
        @(negedge sys_clk);
        chk_en = 1'b0;
    endtask

    task automatic check_rst(input logic exp_rst);
        test_checks++;
        if (rst_core_n_o !== exp_rst) begin
            $display("FAILED %s: rst_core_n_o expected %b actual %b",
                     test_name, exp_rst, rst_core_n_o);
            test_errs++;
        end
    endtask

    // release rst_gen here and watch every edge up to the core release
    task automatic release_and_check(input bit vary_cfg);
        int   edge_cnt;
        bit   ok;
        logic exp_rst;
        edge_cnt = 0;
        ok       = 1'b1;
        rst_gen  = 1'b1;
        while (ok && edge_cnt < REL_EDGES) begin
            @(posedge sys_clk);
            edge_cnt++;
            @(negedge sys_clk);
            exp_rst = (edge_cnt >= REL_EDGES);
            test_checks++;
            if (rst_core_n_o !== exp_rst) begin
                $display("FAILED %s: rst_core_n_o after edge %0d expected %b actual %b",
                         test_name, edge_cnt, exp_rst, rst_core_n_o);
                test_errs++;
                ok = 1'b0;
            end
            if (vary_cfg) begin
                rnd_word = $random(seed);
                apply_cfg(rnd_word[PLL_CFG_W-1:0]);
            end
        end
    endtask

    initial begin
        sys_clk      = 1'b0;
        rst_gen      = 1'b0;
        pll_cfg_i    = '0;
        chk_en       = 1'b0;
        seed         = 32'hb4ff;
        tests_run    = 0;
        tests_failed = 0;
        total_errs   = 0;

        start_test("reset_release");
        repeat (RST_CYCLES) begin
            @(negedge sys_clk);
            check_rst(1'b0);
        end
        release_and_check(1'b0);
        finish_test();

        start_test("exhaustive_decode");
        for (int i = 0; i < 64; i++) begin
            @(negedge sys_clk);
            apply_cfg(6'(i));
        end
        drain_checks();
        finish_test();

        start_test("random_decode");
        repeat (RAND_COUNT) begin
            @(negedge sys_clk);
            rnd_word = $random(seed);
            apply_cfg(rnd_word[PLL_CFG_W-1:0]);
        end
        drain_checks();
        finish_test();

        // core reset must drop well before the next rising edge
        start_test("async_reassert");
        @(negedge sys_clk);
        check_rst(1'b1);
        rst_gen = 1'b0;
        #10;
        check_rst(1'b0);
        repeat (4) begin
            @(negedge sys_clk);
            check_rst(1'b0);
        end
        finish_test();

        // second release, cfg keeps moving through the whole stretch
        start_test("reset_independence");
        release_and_check(1'b1);
        drain_checks();
        finish_test();

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, total_errs);
        if (tests_failed == 0 && total_errs == 0) begin
            $display("TB PASSED");
        end else begin
            $display("TB FAILED");
        end
        $finish;
    end

endmodule

/* verilog/crg_pkg.sv */
package crg_pkg;

    // configuration word layout
    localparam int PLL_CFG_W  = 6;
    localparam int PLL1_SEL_W = 4;
    localparam int PLL2_SEL_W = 2;

    // pll control field widths
    localparam int REFDIV_W  = 6;
    localparam int FBDIV_W   = 12;
    localparam int POSTDIV_W = 3;

    // reset stretch
    localparam int RST_CNT_W = 20;
    localparam logic [RST_CNT_W-1:0] RST_CNT_END = 20'd131071;

    // pll1 integer-N table, fbdiv = base + step * select
    localparam logic [PLL1_SEL_W-1:0] PLL1_SEL_MAX    = 4'd8;
    localparam logic [FBDIV_W-1:0]    PLL1_FBDIV_BASE = 12'd16;
    localparam logic [FBDIV_W-1:0]    PLL1_FBDIV_STEP = 12'd4;
    localparam logic [REFDIV_W-1:0]   PLL1_REFDIV     = 6'd2;
    localparam logic [POSTDIV_W-1:0]  PLL1_POSTDIV1   = 3'd2;
    localparam logic [POSTDIV_W-1:0]  PLL1_POSTDIV2   = 3'd1;

    // pll2 select 1
    localparam logic [REFDIV_W-1:0]  PLL2_MID_REFDIV   = 6'd4;
    localparam logic [FBDIV_W-1:0]   PLL2_MID_FBDIV    = 12'd30;
    localparam logic [POSTDIV_W-1:0] PLL2_MID_POSTDIV1 = 3'd5;
    localparam logic [POSTDIV_W-1:0] PLL2_MID_POSTDIV2 = 3'd1;

    // pll2 select 2
    localparam logic [REFDIV_W-1:0]  PLL2_HI_REFDIV   = 6'd2;
    localparam logic [FBDIV_W-1:0]   PLL2_HI_FBDIV    = 12'd24;
    localparam logic [POSTDIV_W-1:0] PLL2_HI_POSTDIV1 = 3'd3;
    localparam logic [POSTDIV_W-1:0] PLL2_HI_POSTDIV2 = 3'd2;

    // bypass values, same for both plls
    localparam logic [REFDIV_W-1:0]  BYP_REFDIV  = 6'd2;
    localparam logic [FBDIV_W-1:0]   BYP_FBDIV   = 12'd20;
    localparam logic [POSTDIV_W-1:0] BYP_POSTDIV = 3'd1;

endpackage

/* verilog/crg_top.sv */
`timescale 1ns/1ps

module crg_top (
    input  logic                             sys_clk,
    input  logic                             rst_gen,
    input  logic [crg_pkg::PLL_CFG_W-1:0]    pll_cfg_i,
    output logic                             rst_core_n_o,

    output logic                             pll1_bypass_o,
    output logic [crg_pkg::REFDIV_W-1:0]     pll1_refdiv_o,
    output logic [crg_pkg::FBDIV_W-1:0]      pll1_fbdiv_o,
    output logic [crg_pkg::POSTDIV_W-1:0]    pll1_postdiv1_o,
    output logic [crg_pkg::POSTDIV_W-1:0]    pll1_postdiv2_o,

    output logic                             pll2_bypass_o,
    output logic [crg_pkg::REFDIV_W-1:0]     pll2_refdiv_o,
    output logic [crg_pkg::FBDIV_W-1:0]      pll2_fbdiv_o,
    output logic [crg_pkg::POSTDIV_W-1:0]    pll2_postdiv1_o,
    output logic [crg_pkg::POSTDIV_W-1:0]    pll2_postdiv2_o
);

    logic rst_sync_n;
    logic stretch_done;

    pll_ctrl_if pll1_ctrl ();
    pll_ctrl_if pll2_ctrl ();

    // input side synchronizer
    rst_sync u_rst_sync_in (
        .sys_clk      (sys_clk),
        .rst_gen      (rst_gen),
        .rst_sync_n_o (rst_sync_n)
    );

    rst_stretch u_rst_stretch (
        .sys_clk        (sys_clk),
        .rst_gen        (rst_sync_n),
        .stretch_done_o (stretch_done)
    );

    // done level reset-synchronized again before leaving the block
    rst_sync u_rst_sync_out (
        .sys_clk      (sys_clk),
        .rst_gen      (stretch_done),
        .rst_sync_n_o (rst_core_n_o)
    );

    pll_cfg_decode u_pll_cfg_decode (
        .pll_cfg_i (pll_cfg_i),
        .pll1      (pll1_ctrl.src),
        .pll2      (pll2_ctrl.src)
    );

    // pll1 control to pins
    assign pll1_bypass_o   = pll1_ctrl.bypass;
    assign pll1_refdiv_o   = pll1_ctrl.refdiv;
    assign pll1_fbdiv_o    = pll1_ctrl.fbdiv;
    assign pll1_postdiv1_o = pll1_ctrl.postdiv1;
    assign pll1_postdiv2_o = pll1_ctrl.postdiv2;

    // pll2 control to pins
    assign pll2_bypass_o   = pll2_ctrl.bypass;
    assign pll2_refdiv_o   = pll2_ctrl.refdiv;
    assign pll2_fbdiv_o    = pll2_ctrl.fbdiv;
    assign pll2_postdiv1_o = pll2_ctrl.postdiv1;
    assign pll2_postdiv2_o = pll2_ctrl.postdiv2;

endmodule

/* verilog/pll_cfg_decode.sv */
`timescale 1ns/1ps

module pll_cfg_decode (
    input  logic [crg_pkg::PLL_CFG_W-1:0] pll_cfg_i,
    pll_ctrl_if.src                       pll1,
    pll_ctrl_if.src                       pll2
);
    import crg_pkg::*;

    logic [PLL1_SEL_W-1:0] pll1_sel;
    logic [PLL2_SEL_W-1:0] pll2_sel;
    logic                  pll1_in_range;
    logic [FBDIV_W-1:0]    pll1_fbdiv;

    // low nibble picks pll1, top two bits pick pll2
    assign pll1_sel = pll_cfg_i[PLL1_SEL_W-1:0];
    assign pll2_sel = pll_cfg_i[PLL_CFG_W-1:PLL1_SEL_W];

    // select 0 and anything past the table fall back to bypass
    assign pll1_in_range = (pll1_sel != '0) && (pll1_sel <= PLL1_SEL_MAX);

    // linear fbdiv ramp over the select range
    assign pll1_fbdiv = PLL1_FBDIV_BASE + PLL1_FBDIV_STEP * FBDIV_W'(pll1_sel);

    always_comb begin
        if (pll1_in_range) begin
            pll1.bypass   = 1'b0;
            pll1.refdiv   = PLL1_REFDIV;
            pll1.fbdiv    = pll1_fbdiv;
            pll1.postdiv1 = PLL1_POSTDIV1;
            pll1.postdiv2 = PLL1_POSTDIV2;
        end else begin
            pll1.bypass   = 1'b1;
            pll1.refdiv   = BYP_REFDIV;
            pll1.fbdiv    = BYP_FBDIV;
            pll1.postdiv1 = BYP_POSTDIV;
            pll1.postdiv2 = BYP_POSTDIV;
        end
    end

    // pll2 has only two real settings
    always_comb begin
        case (pll2_sel)
            2'd1: begin
                pll2.bypass   = 1'b0;
                pll2.refdiv   = PLL2_MID_REFDIV;
                pll2.fbdiv    = PLL2_MID_FBDIV;
                pll2.postdiv1 = PLL2_MID_POSTDIV1;
                pll2.postdiv2 = PLL2_MID_POSTDIV2;
            end
            2'd2: begin
                pll2.bypass   = 1'b0;
                pll2.refdiv   = PLL2_HI_REFDIV;
                pll2.fbdiv    = PLL2_HI_FBDIV;
                pll2.postdiv1 = PLL2_HI_POSTDIV1;
                pll2.postdiv2 = PLL2_HI_POSTDIV2;
            end
            default: begin
                // selects 0 and 3
                pll2.bypass   = 1'b1;
                pll2.refdiv   = BYP_REFDIV;
                pll2.fbdiv    = BYP_FBDIV;
                pll2.postdiv1 = BYP_POSTDIV;
                pll2.postdiv2 = BYP_POSTDIV;
            end
        endcase
    end

endmodule

/* verilog/pll_ctrl_if.sv */
`timescale 1ns/1ps

interface pll_ctrl_if;
    import crg_pkg::*;

    logic                 bypass;
    logic [REFDIV_W-1:0]  refdiv;
    logic [FBDIV_W-1:0]   fbdiv;
    logic [POSTDIV_W-1:0] postdiv1;
    logic [POSTDIV_W-1:0] postdiv2;

    // decoder side
    modport src (
        output bypass,
        output refdiv,
        output fbdiv,
        output postdiv1,
        output postdiv2
    );

    modport snk (
        input bypass,
        input refdiv,
        input fbdiv,
        input postdiv1,
        input postdiv2
    );

endinterface

/* verilog/rst_stretch.sv */
`timescale 1ns/1ps

module rst_stretch (
    input  logic sys_clk,
    input  logic rst_gen,
    output logic stretch_done_o
);
    import crg_pkg::*;

    logic [RST_CNT_W-1:0] rst_cnt;

    // free-running until terminal count, then holds
    always_ff @(posedge sys_clk or negedge rst_gen) begin
        if (!rst_gen) begin
            rst_cnt <= '0;
        end else if (rst_cnt < RST_CNT_END) begin
            rst_cnt <= rst_cnt + 1'b1;
        end
    end

    // low until the count saturates
    assign stretch_done_o = (rst_cnt == RST_CNT_END);

endmodule

/* verilog/rst_sync.sv */
`timescale 1ns/1ps

module rst_sync (
    input  logic sys_clk,
    input  logic rst_gen,
    output logic rst_sync_n_o
);

    // first two stages, output flop is the third
    logic [1:0] sync_q;

    // assert immediately, release after three edges
    always_ff @(posedge sys_clk or negedge rst_gen) begin
        if (!rst_gen) begin
            sync_q       <= 2'b00;
            rst_sync_n_o <= 1'b0;
        end else begin
            sync_q       <= {sync_q[0], 1'b1};
            rst_sync_n_o <= sync_q[1];
        end
    end

endmodule
